//--- design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // Address geometry
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;

    // Line geometry
    localparam int LINE_WORDS = 4;
    localparam int OFFSET_W   = 4;

    // Word select bits inside a line
    localparam int WSEL_W     = $clog2(LINE_WORDS);

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [WORD_W/8-1:0] mask_t;
    typedef logic [ADDR_W-1:0]   addr_t;

endpackage

`default_nettype wire

//--- design/dcache_way.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_way
    import dcache_pkg::*;
#(
    parameter int SETS = 16,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [IDX_W-1:0]        rd_index,
    input  logic                    wr_en,
    input  logic [IDX_W-1:0]        wr_index,
    input  logic [WSEL_W-1:0]       wr_word_sel,
    input  word_t                   wr_data,
    input  mask_t                   wr_mask,
    input  logic                    set_dirty,
    input  logic                    fill_we,
    input  logic [IDX_W-1:0]        fill_index,
    input  logic [WSEL_W-1:0]       fill_word_sel,
    input  word_t                   fill_data,
    input  logic [TAG_W-1:0]        fill_tag,
    output logic [TAG_W-1:0]        rd_tag,
    output logic                    rd_valid,
    output logic                    rd_dirty,
    output word_t [LINE_WORDS-1:0]  rd_line
);

    logic [TAG_W-1:0]       tag_mem [SETS];
    word_t [LINE_WORDS-1:0] data_mem [SETS];
    logic [SETS-1:0]        valid_q;
    logic [SETS-1:0]        dirty_q;
    logic                   fill_last;

    // Tag goes in with the final refill beat
    assign fill_last = fill_we && (fill_word_sel == WSEL_W'(LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_mem[fill_index][fill_word_sel] <= fill_data;
        end
        if (fill_last) begin
            tag_mem[fill_index] <= fill_tag;
        end
        if (wr_en) begin
            for (int b = 0; b < WORD_W / 8; b++) begin
                if (wr_mask[b]) begin
                    data_mem[wr_index][wr_word_sel][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
        rd_tag  <= tag_mem[rd_index];
        rd_line <= data_mem[rd_index];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            rd_valid <= 1'b0;
            rd_dirty <= 1'b0;
        end else begin
            if (fill_last) begin
                valid_q[fill_index] <= 1'b1;
                dirty_q[fill_index] <= 1'b0;
            end
            if (wr_en && set_dirty) begin
                dirty_q[wr_index] <= 1'b1;
            end
            rd_valid <= valid_q[rd_index];
            rd_dirty <= dirty_q[rd_index];
        end
    end

    // Refill and store hit are never in flight together
    a_fill_store_excl: assert property (
        @(posedge clk) disable iff (rst) !(fill_we && wr_en)
    );

endmodule

`default_nettype wire

//--- design/dcache_plru.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_plru #(
    parameter int SETS = 16,
    parameter int WAYS = 4,
    localparam int IDX_W = $clog2(SETS),
    localparam int WAY_W = $clog2(WAYS)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             access_en,
    input  logic [IDX_W-1:0] access_index,
    input  logic [WAY_W-1:0] access_way,
    input  logic [IDX_W-1:0] victim_index,
    output logic [WAY_W-1:0] victim_way
);

    localparam int NODES = WAYS - 1;

    // Heap order, children of n at 2n+1 and 2n+2
    logic [SETS-1:0][NODES-1:0] tree_q;
    logic [NODES-1:0]           tree_next;
    logic [NODES-1:0]           victim_bits;

    assign victim_bits = tree_q[victim_index];

    // Walk from the root, 0 means left
    always_comb begin
        int node;
        node = 0;
        for (int lvl = 0; lvl < WAY_W; lvl++) begin
            victim_way[WAY_W-1-lvl] = victim_bits[node];
            node = 2 * node + 1 + int'(victim_bits[node]);
        end
    end

    // Point each node on the path away from the accessed way
    always_comb begin
        int node;
        node = 0;
        tree_next = tree_q[access_index];
        for (int lvl = 0; lvl < WAY_W; lvl++) begin
            tree_next[node] = ~access_way[WAY_W-1-lvl];
            node = 2 * node + 1 + int'(access_way[WAY_W-1-lvl]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tree_q <= '0;
        end else if (access_en) begin
            tree_q[access_index] <= tree_next;
        end
    end

endmodule

`default_nettype wire

//--- design/dcache_miss.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_miss
    import dcache_pkg::*;
#(
    parameter int SETS = 16,
    parameter int WAYS = 4,
    localparam int IDX_W = $clog2(SETS),
    localparam int WAY_W = $clog2(WAYS),
    localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              miss_start,
    input  addr_t             miss_addr,
    input  logic [WAY_W-1:0]  victim_way,
    input  logic              victim_dirty,
    input  logic [TAG_W-1:0]  victim_tag,
    input  logic              mem_rd_valid,
    input  word_t             mem_rd_data,
    input  logic              wb_finished,
    output logic              wb_start,
    output addr_t             wb_addr,
    output logic              mem_rd_req,
    output addr_t             mem_rd_addr,
    output logic [WAYS-1:0]   fill_we,
    output logic [IDX_W-1:0]  fill_index,
    output logic [WSEL_W-1:0] fill_word_sel,
    output word_t             fill_data,
    output logic [TAG_W-1:0]  fill_tag,
    output logic              miss_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_WB,
        S_REQ,
        S_FILL,
        S_DONE
    } state_t;

    state_t                     state;
    logic [ADDR_W-OFFSET_W-1:0] line_q;
    logic [WAY_W-1:0]           way_q;
    logic [WSEL_W-1:0]          beat;
    logic                       accept;

    assign accept = (state == S_IDLE) && miss_start;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (miss_start) begin
                        state <= victim_dirty ? S_WB : S_REQ;
                    end
                end
                S_WB: begin
                    if (wb_finished) begin
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    state <= S_FILL;
                    beat  <= '0;
                end
                S_FILL: begin
                    if (mem_rd_valid) begin
                        beat <= beat + 1'b1;
                        if (beat == WSEL_W'(LINE_WORDS - 1)) begin
                            state <= S_DONE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            line_q <= miss_addr[ADDR_W-1:OFFSET_W];
            way_q  <= victim_way;
        end
    end

    // Victim line is still on the way outputs in the accept cycle
    assign wb_start = accept && victim_dirty;
    assign wb_addr  = {victim_tag, miss_addr[OFFSET_W +: IDX_W], {OFFSET_W{1'b0}}};

    assign mem_rd_req  = (state == S_REQ);
    assign mem_rd_addr = {line_q, {OFFSET_W{1'b0}}};

    always_comb begin
        fill_we        = '0;
        fill_we[way_q] = (state == S_FILL) && mem_rd_valid;
    end

    assign fill_index    = line_q[IDX_W-1:0];
    assign fill_tag      = line_q[IDX_W +: TAG_W];
    assign fill_word_sel = beat;
    assign fill_data     = mem_rd_data;
    assign miss_done     = (state == S_DONE);

    a_rd_only_in_fill: assert property (
        @(posedge clk) disable iff (rst) mem_rd_valid |-> state == S_FILL
    );

endmodule

`default_nettype wire

//--- design/dcache_writeback.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_writeback
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_start,
    input  addr_t                  wb_addr,
    input  word_t [LINE_WORDS-1:0] wb_line,
    input  logic                   mem_wr_done,
    output logic                   mem_wr_valid,
    output addr_t                  mem_wr_addr,
    output word_t                  mem_wr_data,
    output logic                   wb_finished
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_SEND,
        W_WAIT
    } wstate_t;

    wstate_t                state;
    word_t [LINE_WORDS-1:0] line_q;
    addr_t                  base_q;
    logic [WSEL_W-1:0]      beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= W_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                W_IDLE: begin
                    if (wb_start) begin
                        state <= W_SEND;
                        beat  <= '0;
                    end
                end
                W_SEND: begin
                    beat <= beat + 1'b1;
                    if (beat == WSEL_W'(LINE_WORDS - 1)) begin
                        state <= W_WAIT;
                    end
                end
                W_WAIT: begin
                    if (mem_wr_done) begin
                        state <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wb_start && state == W_IDLE) begin
            line_q <= wb_line;
            base_q <= wb_addr;
        end
    end

    // One word per cycle, lowest first
    assign mem_wr_valid = (state == W_SEND);
    assign mem_wr_addr  = base_q + addr_t'({beat, 2'b00});
    assign mem_wr_data  = line_q[beat];
    assign wb_finished  = (state == W_WAIT) && mem_wr_done;

endmodule

`default_nettype wire

//--- design/dcache.sv
`timescale 1ns/1ns
`default_nettype none

module dcache
    import dcache_pkg::*;
#(
    parameter int SETS = 16,
    parameter int WAYS = 4,
    localparam int IDX_W = $clog2(SETS),
    localparam int WAY_W = $clog2(WAYS),
    localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  load_req,
    input  addr_t load_addr,
    input  logic  store_req,
    input  addr_t store_addr,
    input  word_t store_data,
    input  mask_t store_mask,
    input  logic  mem_rd_valid,
    input  word_t mem_rd_data,
    input  logic  mem_wr_done,
    output logic  load_valid,
    output word_t load_data,
    output logic  store_done,
    output logic  busy,
    output logic  mem_rd_req,
    output addr_t mem_rd_addr,
    output logic  mem_wr_valid,
    output addr_t mem_wr_addr,
    output word_t mem_wr_data
);

    logic              req_any;
    addr_t             req_addr;
    logic [IDX_W-1:0]  rd_index;

    // Hit stage registers
    logic              s1_valid;
    logic              s1_load;
    addr_t             s1_addr;
    word_t             s1_data;
    mask_t             s1_mask;
    logic [IDX_W-1:0]  s1_index;
    logic [TAG_W-1:0]  s1_tag;
    logic [WSEL_W-1:0] s1_sel;

    logic [TAG_W-1:0]       rd_tag [WAYS];
    logic [WAYS-1:0]        rd_valid;
    logic [WAYS-1:0]        rd_dirty;
    word_t [LINE_WORDS-1:0] rd_line [WAYS];

    logic [WAYS-1:0]   way_hit;
    logic              hit;
    logic [WAY_W-1:0]  hit_way;
    logic              store_hit;
    logic [WAY_W-1:0]  victim_way;
    logic              miss_start;
    logic              miss_done;

    logic [WAYS-1:0]   fill_we;
    logic [IDX_W-1:0]  fill_index;
    logic [WSEL_W-1:0] fill_word_sel;
    word_t             fill_data;
    logic [TAG_W-1:0]  fill_tag;
    logic              wb_start;
    addr_t             wb_addr;
    logic              wb_finished;

    assign req_any  = load_req | store_req;
    assign req_addr = load_req ? load_addr : store_addr;
    // Hold the pending index so the victim and replay see the same set
    assign rd_index = req_any ? req_addr[OFFSET_W +: IDX_W] : s1_index;

    assign s1_index = s1_addr[OFFSET_W +: IDX_W];
    assign s1_tag   = s1_addr[ADDR_W-1 -: TAG_W];
    assign s1_sel   = s1_addr[2 +: WSEL_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_any | miss_done;
        end
    end

    always_ff @(posedge clk) begin
        if (req_any) begin
            s1_load <= load_req;
            s1_addr <= req_addr;
            s1_data <= store_data;
            s1_mask <= store_mask;
        end
    end

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < WAYS; i++) begin
            way_hit[i] = rd_valid[i] && (rd_tag[i] == s1_tag);
            if (way_hit[i]) begin
                hit_way = WAY_W'(i);
            end
        end
    end

    assign hit        = |way_hit;
    assign store_hit  = s1_valid && hit && !s1_load;
    assign miss_start = s1_valid && !hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            load_valid <= 1'b0;
            store_done <= 1'b0;
            busy       <= 1'b0;
        end else begin
            load_valid <= s1_valid && hit && s1_load;
            store_done <= store_hit;
            if (miss_start) begin
                busy <= 1'b1;
            end else if (s1_valid && hit) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        load_data <= rd_line[hit_way][s1_sel];
    end

    for (genvar i = 0; i < WAYS; i++) begin : g_way
        dcache_way #(
            .SETS(SETS)
        ) u_way (
            .clk          (clk),
            .rst          (rst),
            .rd_index     (rd_index),
            .wr_en        (store_hit && way_hit[i]),
            .wr_index     (s1_index),
            .wr_word_sel  (s1_sel),
            .wr_data      (s1_data),
            .wr_mask      (s1_mask),
            .set_dirty    (|s1_mask),
            .fill_we      (fill_we[i]),
            .fill_index   (fill_index),
            .fill_word_sel(fill_word_sel),
            .fill_data    (fill_data),
            .fill_tag     (fill_tag),
            .rd_tag       (rd_tag[i]),
            .rd_valid     (rd_valid[i]),
            .rd_dirty     (rd_dirty[i]),
            .rd_line      (rd_line[i])
        );
    end

    // Replay after refill counts as a hit, so fills update PLRU too
    dcache_plru #(
        .SETS(SETS),
        .WAYS(WAYS)
    ) u_plru (
        .clk         (clk),
        .rst         (rst),
        .access_en   (s1_valid && hit),
        .access_index(s1_index),
        .access_way  (hit_way),
        .victim_index(s1_index),
        .victim_way  (victim_way)
    );

    dcache_miss #(
        .SETS(SETS),
        .WAYS(WAYS)
    ) u_miss (
        .clk          (clk),
        .rst          (rst),
        .miss_start   (miss_start),
        .miss_addr    (s1_addr),
        .victim_way   (victim_way),
        .victim_dirty (rd_dirty[victim_way]),
        .victim_tag   (rd_tag[victim_way]),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data),
        .wb_finished  (wb_finished),
        .wb_start     (wb_start),
        .wb_addr      (wb_addr),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .fill_we      (fill_we),
        .fill_index   (fill_index),
        .fill_word_sel(fill_word_sel),
        .fill_data    (fill_data),
        .fill_tag     (fill_tag),
        .miss_done    (miss_done)
    );

    dcache_writeback u_writeback (
        .clk         (clk),
        .rst         (rst),
        .wb_start    (wb_start),
        .wb_addr     (wb_addr),
        .wb_line     (rd_line[victim_way]),
        .mem_wr_done (mem_wr_done),
        .mem_wr_valid(mem_wr_valid),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .wb_finished (wb_finished)
    );

    a_single_req: assert property (
        @(posedge clk) disable iff (rst) !(load_req && store_req)
    );

    // Blocking cache, nothing new while a miss is open
    a_no_req_busy: assert property (
        @(posedge clk) disable iff (rst) busy |-> !req_any
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
();

    localparam int SETS           = 16;
    localparam int WAYS           = 4;
    localparam int MEM_WORDS      = 4096;
    localparam int RESULT_TIMEOUT = 200;
    localparam int BUSY_TIMEOUT   = 200;
    localparam int RESET_TIMEOUT  = 20;
    // Result edge follows the request edge, so the second negedge sees it
    localparam int HIT_CYCLES     = 2;
    localparam logic [3:0] OP_STORE = 4'h1;
    localparam addr_t NO_WB       = 32'hffff_ffff;

    logic  clk;
    logic  rst;
    logic  load_req;
    addr_t load_addr;
    logic  store_req;
    addr_t store_addr;
    word_t store_data;
    mask_t store_mask;
    logic  mem_rd_valid;
    word_t mem_rd_data;
    logic  mem_wr_done;
    logic  load_valid;
    word_t load_data;
    logic  store_done;
    logic  busy;
    logic  mem_rd_req;
    addr_t mem_rd_addr;
    logic  mem_wr_valid;
    addr_t mem_wr_addr;
    word_t mem_wr_data;

    word_t       mem [MEM_WORDS];
    word_t       ref_mem [MEM_WORDS];
    int unsigned lcg_state = 93536;
    int          errors = 0;
    int          timeouts = 0;
    int          fetch_count = 0;
    addr_t       last_fetch;
    logic        wb_open = 1'b0;
    int          wb_beats = 0;
    addr_t       wb_addr_log [8];
    word_t       wb_data_log [8];

    tb_clock #(
        .HALF_PERIOD (4),
        .RESET_CYCLES(5)
    ) u_clock (
        .clk(clk),
        .rst(rst)
    );

    dcache #(
        .SETS(SETS),
        .WAYS(WAYS)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .load_req    (load_req),
        .load_addr   (load_addr),
        .store_req   (store_req),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .store_mask  (store_mask),
        .mem_rd_valid(mem_rd_valid),
        .mem_rd_data (mem_rd_data),
        .mem_wr_done (mem_wr_done),
        .load_valid  (load_valid),
        .load_data   (load_data),
        .store_done  (store_done),
        .busy        (busy),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_addr (mem_rd_addr),
        .mem_wr_valid(mem_wr_valid),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data)
    );

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic int word_index(input addr_t a);
        return int'(a[2 +: 12]);
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Memory side, line fetch with random gaps between beats
    always begin : fetch_model
        int    gap;
        addr_t base;
        @(negedge clk);
        if (mem_rd_req) begin
            base = mem_rd_addr;
            fetch_count++;
            last_fetch = base;
            if (wb_open) begin
                $display("Line fetch at %h started before the write-back finished", base);
                errors++;
            end
            for (int b = 0; b < LINE_WORDS; b++) begin
                gap = lcg_next() % 3;
                repeat (gap) begin
                    @(posedge clk);
                    mem_rd_valid <= 1'b0;
                end
                @(posedge clk);
                mem_rd_valid <= 1'b1;
                mem_rd_data  <= mem[word_index(base + 4 * b)];
            end
            @(posedge clk);
            mem_rd_valid <= 1'b0;
        end
    end

    // Memory side, write-back capture and delayed confirm
    always begin : writeback_model
        int delay;
        @(negedge clk);
        if (mem_wr_valid) begin
            wb_open = 1'b1;
            if (wb_beats < 8) begin
                wb_addr_log[wb_beats] = mem_wr_addr;
                wb_data_log[wb_beats] = mem_wr_data;
            end
            mem[word_index(mem_wr_addr)] = mem_wr_data;
            wb_beats++;
            if (wb_beats % LINE_WORDS == 0) begin
                delay = lcg_next() % 4;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                mem_wr_done <= 1'b1;
                @(posedge clk);
                mem_wr_done <= 1'b0;
                wb_open = 1'b0;
            end
        end
    end

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy && n < BUSY_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("Timeout: cache stayed busy for %0d cycles", BUSY_TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic check_writeback(input addr_t line);
        if (line == NO_WB) begin
            if (wb_beats != 0) begin
                $display("Unexpected write-back of %0d beats", wb_beats);
                errors++;
            end
        end else if (wb_beats != LINE_WORDS) begin
            $display("Line %h needed %0d write-back beats but saw %0d",
                     line, LINE_WORDS, wb_beats);
            errors++;
        end else begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                check_addr("mem_wr_addr", wb_addr_log[i], line + 4 * i);
                check_word("mem_wr_data", wb_data_log[i], ref_mem[word_index(line + 4 * i)]);
            end
        end
    endtask

    task automatic run_op(input logic [3:0] op, input addr_t addr, input word_t data,
                          input mask_t mask, input word_t exp_load,
                          input logic exp_fetch, input addr_t exp_wb);
        int   cycles;
        int   fetches_before;
        logic seen;
        logic busy_early;
        wait_not_busy();
        fetches_before = fetch_count;
        wb_beats = 0;
        @(posedge clk);
        if (op == OP_STORE) begin
            store_req  <= 1'b1;
            store_addr <= addr;
            store_data <= data;
            store_mask <= mask;
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    ref_mem[word_index(addr)][8*b +: 8] = data[8*b +: 8];
                end
            end
        end else begin
            load_req  <= 1'b1;
            load_addr <= addr;
        end
        @(posedge clk);
        load_req  <= 1'b0;
        store_req <= 1'b0;
        cycles     = 0;
        seen       = 1'b0;
        busy_early = 1'b0;
        while (!seen && cycles < RESULT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            // A miss raises busy one cycle after the request
            if (cycles == HIT_CYCLES) begin
                busy_early = busy;
            end
            seen = (op == OP_STORE) ? store_done : load_valid;
        end
        if (!seen) begin
            $display("Timeout: no result for the access at %h", addr);
            timeouts++;
        end else begin
            if (op != OP_STORE) begin
                check_word("load_data", load_data, exp_load);
            end
            check_flag("busy", busy_early, exp_fetch);
            // Busy drops together with the result pulse
            check_flag("busy", busy, 1'b0);
            if (!exp_fetch && cycles != HIT_CYCLES) begin
                $display("Hit at %h answered after %0d cycles instead of %0d",
                         addr, cycles, HIT_CYCLES);
                errors++;
            end
        end
        if (exp_fetch) begin
            if (fetch_count - fetches_before != 1) begin
                $display("Access at %h should fetch one line but fetched %0d",
                         addr, fetch_count - fetches_before);
                errors++;
            end else begin
                check_addr("mem_rd_addr", last_fetch, addr & ~addr_t'(15));
            end
        end else if (fetch_count != fetches_before) begin
            $display("Access at %h should hit but fetched a line", addr);
            errors++;
        end
        check_writeback(exp_wb);
    endtask

    initial begin : main_seq
        logic [3:0]       op;
        addr_t            addr;
        word_t            data;
        mask_t            mask;
        word_t            exp_load;
        logic             exp_fetch;
        addr_t            exp_wb;
        int               fd;
        int               code;
        int               n;
        int               n_ops;
        logic [8*256-1:0] junk;
        load_req     = 1'b0;
        load_addr    = '0;
        store_req    = 1'b0;
        store_addr   = '0;
        store_data   = '0;
        store_mask   = '0;
        mem_rd_valid = 1'b0;
        mem_rd_data  = '0;
        mem_wr_done  = 1'b0;
        n_ops = 0;
        // Each word holds its byte address XOR 5A5A0000
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = word_t'(i * 4) ^ 32'h5A5A_0000;
            ref_mem[i] = mem[i];
        end
        n = 0;
        @(negedge clk);
        while (rst && n < RESET_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rst) begin
            $display("Timeout: reset never released");
            timeouts++;
        end
        fd = $fopen("bench/dcache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %h %h %h %h %h %h %h",
                               op, addr, data, mask, exp_load, exp_fetch, exp_wb);
                if (code == 7) begin
                    run_op(op, addr, data, mask, exp_load, exp_fetch, exp_wb);
                    n_ops++;
                end else begin
                    code = $fgets(junk, fd);
                end
            end
            $fclose(fd);
        end
        if (n_ops == 0) begin
            $display("No operations were read from the stimulus file");
            errors++;
        end
        $display("Run finished: %0d operations, %0d errors, %0d timeouts",
                 n_ops, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/dcache_pkg.sv
design/dcache_way.sv
design/dcache_plru.sv
design/dcache_miss.sv
design/dcache_writeback.sv
design/dcache.sv
bench/tb_clock.sv
bench/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - design/dcache_pkg.sv
      - design/dcache_way.sv
      - design/dcache_plru.sv
      - design/dcache_miss.sv
      - design/dcache_writeback.sv
      - design/dcache.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/tb_dcache.sv

//--- bench/dcache_stimulus.txt
# op (0 load, 1 store), byte address, store data, store mask, expected load data,
# line fetch expected (1) or hit (0), written-back line address (ffffffff for none)
# Cold load, then a hit in the same line
0 00001004 00000000 0 5a5a1004 1 ffffffff
0 0000100c 00000000 0 5a5a100c 0 ffffffff
# Partial store to a resident line
1 00001008 aabbccdd 5 00000000 0 ffffffff
0 00001008 00000000 0 5abb10dd 0 ffffffff
# Store to an absent line allocates it
1 00002014 11223344 f 00000000 1 ffffffff
0 00002014 00000000 0 11223344 0 ffffffff
0 00002018 00000000 0 5a5a2018 0 ffffffff
# Set 3, the hit on 0030 leaves 0130 as victim
0 00000030 00000000 0 5a5a0030 1 ffffffff
0 00000130 00000000 0 5a5a0130 1 ffffffff
0 00000234 00000000 0 5a5a0234 1 ffffffff
0 0000033c 00000000 0 5a5a033c 1 ffffffff
0 00000038 00000000 0 5a5a0038 0 ffffffff
0 00000430 00000000 0 5a5a0430 1 ffffffff
# Reload of 0130 takes the way of 0230
0 00000130 00000000 0 5a5a0130 1 ffffffff
0 00000030 00000000 0 5a5a0030 0 ffffffff
0 00000330 00000000 0 5a5a0330 0 ffffffff
0 00000434 00000000 0 5a5a0434 0 ffffffff
# Dirty line 1000 goes out when 1400 arrives
0 00001100 00000000 0 5a5a1100 1 ffffffff
0 00001200 00000000 0 5a5a1200 1 ffffffff
0 00001300 00000000 0 5a5a1300 1 ffffffff
0 00001400 00000000 0 5a5a1400 1 00001000
0 00001008 00000000 0 5abb10dd 1 ffffffff
